//--- conv_sobel.f
source/conv_pkg.sv
source/compute_unit.sv
source/conv_engine_2d.sv
source/result_queue.sv
source/write_arbiter.sv
source/result_ram.sv
source/sobel_top.sv
sim/sobel_properties.sv
sim/sobel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module sobel_tb -f conv_sobel.f \
	--Mdir obj_dir -o sobel_sim \
	&& out=$(./obj_dir/sobel_sim) ; echo "$out" \
	&& echo "$out" | grep -F '*** TEST PASSED ***' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/sobel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_tb;

	localparam int IMG_W = conv_pkg::IMG_WIDTH_DEFAULT;
	localparam int IMG_H = conv_pkg::IMG_HEIGHT_DEFAULT;
	localparam int OUT_W = IMG_W - 2;
	localparam int OUT_COUNT = (IMG_W - 2) * (IMG_H - 2);
	localparam int IDX_W = $clog2(OUT_COUNT);
	localparam int ADDR_W = IDX_W + 1;
	localparam int WORDS = 2 * OUT_COUNT;
	localparam int NUM_ROWS = 10;

	localparam int PAT_CONST = 0;
	localparam int PAT_HRAMP = 1;
	localparam int PAT_VRAMP = 2;
	localparam int PAT_CHECKER = 3;
	localparam int PAT_RANDOM = 4;

	// what a kernel output must look like beyond the reference match.
	localparam int KIND_REF = 0;
	localparam int KIND_ZERO = 1;
	localparam int KIND_UNIFORM = 2;

	logic                clk = 1'b0;
	logic                rst;
	logic                start;
	logic [7:0]          pixel_in;
	logic                pixel_valid;
	logic [ADDR_W-1:0]   rd_addr;
	logic signed [21:0]  rd_data;
	logic                frame_done;

	string  row_name [NUM_ROWS];
	int     row_pattern [NUM_ROWS];
	int     row_gap [NUM_ROWS];
	int     row_x_kind [NUM_ROWS];
	int     row_y_kind [NUM_ROWS];
	int     row_x_level [NUM_ROWS];
	int     row_y_level [NUM_ROWS];
	int     num_rows = 0;
	int     frame [0:IMG_H-1][0:IMG_W-1];
	integer seed = 32'hb2e1b3a6;
	int     cycle_count = 0;
	int     timeout_limit = 0;
	int     done_count = 0;

	sobel_top #(.IMG_WIDTH(IMG_W), .IMG_HEIGHT(IMG_H)) u_dut (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.pixel_in    (pixel_in),
		.pixel_valid (pixel_valid),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.frame_done  (frame_done)
	);

	bind write_arbiter sobel_properties u_props (
		.clk         (clk),
		.rst         (rst),
		.not_empty_x (not_empty_x),
		.not_empty_y (not_empty_y),
		.pop_x       (pop_x),
		.pop_y       (pop_y),
		.wr_en       (wr_en),
		.frame_done  (frame_done)
	);

	always #10 clk = ~clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (frame_done) begin
			done_count <= done_count + 1;
		end
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			fail_run($sformatf("timeout, the run did not finish within %0d cycles", timeout_limit));
		end
	end

	task automatic add_row(input string name, input int pattern, input int gap,
			input int x_kind, input int y_kind, input int x_level, input int y_level);
		row_name[num_rows] = name;
		row_pattern[num_rows] = pattern;
		row_gap[num_rows] = gap;
		row_x_kind[num_rows] = x_kind;
		row_y_kind[num_rows] = y_kind;
		row_x_level[num_rows] = x_level;
		row_y_level[num_rows] = y_level;
		num_rows++;
	endtask

	// sobel x scales rows 1 2 1 and takes left minus right; y scales columns and takes top
	// minus bottom.
	function automatic int kernel_weight(input int sel, input int i, input int j);
		int scale;
		if (sel == 0) begin
			scale = (i == 1) ? 2 : 1;
			return (j == 0) ? scale : ((j == 2) ? -scale : 0);
		end
		scale = (j == 1) ? 2 : 1;
		return (i == 0) ? scale : ((i == 2) ? -scale : 0);
	endfunction

	// word n is the n-th x result, then the n-th y result after OUT_COUNT.
	function automatic int reference_word(input int word);
		int sel;
		int idx;
		int x;
		int y;
		int acc;
		sel = (word >= OUT_COUNT) ? 1 : 0;
		idx = word - sel * OUT_COUNT;
		x = idx % OUT_W + 2;
		y = idx / OUT_W + 2;
		acc = 0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				acc += kernel_weight(sel, i, j) * frame[y-2+i][x-2+j];
			end
		end
		return acc;
	endfunction

	function automatic int word_address(input int word);
		if (word >= OUT_COUNT) begin
			return (1 << IDX_W) + (word - OUT_COUNT);
		end
		return word;
	endfunction

	task automatic send_frame(input int r);
		int value;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				case (row_pattern[r])
					PAT_CONST:   value = 77;
					PAT_HRAMP:   value = 5 * x;
					PAT_VRAMP:   value = 7 * y;
					PAT_CHECKER: value = ((x + y) % 2 == 1) ? 255 : 0;
					default:     value = $random(seed) & 255;
				endcase
				frame[y][x] = value;
				pixel_in = 8'(value);
				pixel_valid = 1'b1;
				@(posedge clk);
				#1;
				pixel_valid = 1'b0;
				repeat (row_gap[r]) begin
					@(posedge clk);
					#1;
				end
			end
		end
	endtask

	// reads are pipelined so each cycle returns the word for the previous address.
	task automatic read_back(input int r);
		int actual;
		int kind;
		int level;
		string name;
		for (int n = 0; n <= WORDS; n++) begin
			@(posedge clk);
			#1;
			if (n > 0) begin
				actual = int'(rd_data);
				name = $sformatf("%s word %0d", row_name[r], n - 1);
				check_value(name, reference_word(n - 1), actual);
				kind = (n - 1 < OUT_COUNT) ? row_x_kind[r] : row_y_kind[r];
				level = (n - 1 < OUT_COUNT) ? row_x_level[r] : row_y_level[r];
				if (kind == KIND_ZERO) begin
					check_value({name, " zero"}, 0, actual);
				end else if (kind == KIND_UNIFORM) begin
					check_value({name, " uniform"}, level, actual);
				end
			end
			if (n < WORDS) begin
				rd_addr = ADDR_W'(word_address(n));
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		pixel_in = '0;
		pixel_valid = 1'b0;
		rd_addr = '0;

		// a ramp of step s gives -8 s across its kernel, -40 for hramp and -56 for vramp.
		add_row("const_gap1", PAT_CONST, 1, KIND_ZERO, KIND_ZERO, 0, 0);
		add_row("hramp_gap1", PAT_HRAMP, 1, KIND_UNIFORM, KIND_ZERO, -40, 0);
		add_row("vramp_gap1", PAT_VRAMP, 1, KIND_ZERO, KIND_UNIFORM, 0, -56);
		add_row("checker_gap1", PAT_CHECKER, 1, KIND_REF, KIND_REF, 0, 0);
		add_row("random_gap1", PAT_RANDOM, 1, KIND_REF, KIND_REF, 0, 0);
		add_row("checker_gap3", PAT_CHECKER, 3, KIND_REF, KIND_REF, 0, 0);
		add_row("random_gap3", PAT_RANDOM, 3, KIND_REF, KIND_REF, 0, 0);
		add_row("const_gap3", PAT_CONST, 3, KIND_ZERO, KIND_ZERO, 0, 0);
		add_row("vramp_gap3", PAT_VRAMP, 3, KIND_ZERO, KIND_UNIFORM, 0, -56);
		add_row("hramp_gap3", PAT_HRAMP, 3, KIND_UNIFORM, KIND_ZERO, -40, 0);

		for (int r = 0; r < num_rows; r++) begin
			timeout_limit += IMG_W * IMG_H * (row_gap[r] + 1) + WORDS + 200;
		end

		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < num_rows; r++) begin
			check_value({row_name[r], " frame_done count before start"}, r, done_count);
			send_frame(r);
			do begin
				@(posedge clk);
				#1;
			end while (frame_done !== 1'b1);
			read_back(r);
			check_value({row_name[r], " frame_done count"}, r + 1, done_count);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/sobel_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_properties (
	input logic clk,
	input logic rst,
	input logic not_empty_x,
	input logic not_empty_y,
	input logic pop_x,
	input logic pop_y,
	input logic wr_en,
	input logic frame_done
);

	// no result may reach the memory once the frame is reported done.
	a_no_write_at_done: assert property (
		@(posedge clk) disable iff (rst)
		frame_done |-> !wr_en
	) else $error("memory write in the frame_done cycle");

	// a queue that lost a conflict is served next.
	a_turn_x: assert property (
		@(posedge clk) disable iff (rst)
		(pop_y && not_empty_x) |=> pop_x
	) else $error("queue x not served after waiting behind queue y");

	a_turn_y: assert property (
		@(posedge clk) disable iff (rst)
		(pop_x && not_empty_y) |=> pop_y
	) else $error("queue y not served after waiting behind queue x");

	// frame done is a one-cycle pulse.
	a_done_pulse: assert property (
		@(posedge clk) disable iff (rst)
		frame_done |=> !frame_done
	) else $error("frame_done high for two cycles in a row");

endmodule

`default_nettype wire

//--- source/sobel_top.sv
`timescale 1ns/1ps
`default_nettype none

module sobel_top #(
	parameter int IMG_WIDTH  = conv_pkg::IMG_WIDTH_DEFAULT,
	parameter int IMG_HEIGHT = conv_pkg::IMG_HEIGHT_DEFAULT
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 start,
	input  logic [conv_pkg::PIXEL_W-1:0]         pixel_in,
	input  logic                                 pixel_valid,
	input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)):0] rd_addr,
	output logic signed [conv_pkg::RESULT_W-1:0] rd_data,
	output logic                                 frame_done
);

	localparam int IDX_W = $clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2));

	logic                                 valid_x, valid_y;
	logic [IDX_W-1:0]                     index_x, index_y;
	logic signed [conv_pkg::RESULT_W-1:0] result_x, result_y;
	logic                                 done_x, done_y;
	logic                                 not_empty_x, not_empty_y;
	logic [IDX_W-1:0]                     head_index_x, head_index_y;
	logic signed [conv_pkg::RESULT_W-1:0] head_result_x, head_result_y;
	logic                                 pop_x, pop_y;
	logic                                 wr_en;
	logic [IDX_W:0]                       wr_addr;
	logic signed [conv_pkg::RESULT_W-1:0] wr_data;

	conv_engine_2d #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT),
		.KERNEL     (conv_pkg::SOBEL_X)
	) u_engine_x (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.pixel_in     (pixel_in),
		.pixel_valid  (pixel_valid),
		.result_out   (result_x),
		.result_index (index_x),
		.result_valid (valid_x),
		.done         (done_x)
	);

	conv_engine_2d #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT),
		.KERNEL     (conv_pkg::SOBEL_Y)
	) u_engine_y (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.pixel_in     (pixel_in),
		.pixel_valid  (pixel_valid),
		.result_out   (result_y),
		.result_index (index_y),
		.result_valid (valid_y),
		.done         (done_y)
	);

	result_queue #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_queue_x (
		.clk         (clk),
		.rst         (rst),
		.push        (valid_x),
		.push_index  (index_x),
		.push_result (result_x),
		.pop         (pop_x),
		.not_empty   (not_empty_x),
		.head_index  (head_index_x),
		.head_result (head_result_x)
	);

	result_queue #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_queue_y (
		.clk         (clk),
		.rst         (rst),
		.push        (valid_y),
		.push_index  (index_y),
		.push_result (result_y),
		.pop         (pop_y),
		.not_empty   (not_empty_y),
		.head_index  (head_index_y),
		.head_result (head_result_y)
	);

	write_arbiter #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_arbiter (
		.clk           (clk),
		.rst           (rst),
		.not_empty_x   (not_empty_x),
		.not_empty_y   (not_empty_y),
		.head_index_x  (head_index_x),
		.head_index_y  (head_index_y),
		.head_result_x (head_result_x),
		.head_result_y (head_result_y),
		.done_x        (done_x),
		.done_y        (done_y),
		.pop_x         (pop_x),
		.pop_y         (pop_y),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.frame_done    (frame_done)
	);

	result_ram #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

//--- source/result_ram.sv
`timescale 1ns/1ps
`default_nettype none

module result_ram #(
	parameter int IMG_WIDTH  = conv_pkg::IMG_WIDTH_DEFAULT,
	parameter int IMG_HEIGHT = conv_pkg::IMG_HEIGHT_DEFAULT
) (
	input  logic                                 clk,
	input  logic                                 wr_en,
	input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)):0] wr_addr,
	input  logic signed [conv_pkg::RESULT_W-1:0] wr_data,
	input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)):0] rd_addr,
	output logic signed [conv_pkg::RESULT_W-1:0] rd_data
);

	localparam int IDX_W = $clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2));
	// lower half holds the x results, upper half the y results.
	localparam int DEPTH = 2 * (2 ** IDX_W);

	logic signed [conv_pkg::RESULT_W-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- source/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_arbiter #(
	parameter int IMG_WIDTH  = conv_pkg::IMG_WIDTH_DEFAULT,
	parameter int IMG_HEIGHT = conv_pkg::IMG_HEIGHT_DEFAULT
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 not_empty_x,
	input  logic                                 not_empty_y,
	input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2))-1:0] head_index_x,
	input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2))-1:0] head_index_y,
	input  logic signed [conv_pkg::RESULT_W-1:0] head_result_x,
	input  logic signed [conv_pkg::RESULT_W-1:0] head_result_y,
	input  logic                                 done_x,
	input  logic                                 done_y,
	output logic                                 pop_x,
	output logic                                 pop_y,
	output logic                                 wr_en,
	output logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)):0] wr_addr,
	output logic signed [conv_pkg::RESULT_W-1:0] wr_data,
	output logic                                 frame_done
);

	logic last_y;
	logic done_seen_x;
	logic done_seen_y;
	logic finish;

	// x wins a conflict when y was granted last.
	assign pop_x = not_empty_x && (!not_empty_y || last_y);
	assign pop_y = not_empty_y && !pop_x;

	assign wr_en = pop_x || pop_y;
	assign wr_addr = pop_y ? {1'b1, head_index_y} : {1'b0, head_index_x};
	assign wr_data = pop_y ? head_result_y : head_result_x;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_y <= 1'b0;
		end else if (wr_en) begin
			last_y <= pop_y;
		end
	end

	// both engines finished and every result is in memory.
	assign finish = done_seen_x && done_seen_y && !not_empty_x && !not_empty_y;

	always_ff @(posedge clk) begin
		if (rst || finish) begin
			done_seen_x <= 1'b0;
			done_seen_y <= 1'b0;
		end else begin
			done_seen_x <= done_seen_x || done_x;
			done_seen_y <= done_seen_y || done_y;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_done <= 1'b0;
		end else begin
			frame_done <= finish;
		end
	end

endmodule

`default_nettype wire

//--- source/result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module result_queue #(
	parameter int IMG_WIDTH  = conv_pkg::IMG_WIDTH_DEFAULT,
	parameter int IMG_HEIGHT = conv_pkg::IMG_HEIGHT_DEFAULT
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 push,
	input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2))-1:0] push_index,
	input  logic signed [conv_pkg::RESULT_W-1:0] push_result,
	input  logic                                 pop,
	output logic                                 not_empty,
	output logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2))-1:0] head_index,
	output logic signed [conv_pkg::RESULT_W-1:0] head_result
);

	localparam int IDX_W = $clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2));

	logic [IDX_W-1:0]                  idx_mem [0:1];
	logic signed [conv_pkg::RESULT_W-1:0] res_mem [0:1];
	logic                              wr_ptr;
	logic                              rd_ptr;
	logic [1:0]                        count;

	always_ff @(posedge clk) begin
		if (push) begin
			idx_mem[wr_ptr] <= push_index;
			res_mem[wr_ptr] <= push_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			// simultaneous push and pop leave the count unchanged.
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign not_empty = (count != 2'd0);
	assign head_index = idx_mem[rd_ptr];
	assign head_result = res_mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/conv_engine_2d.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine_2d #(
	parameter int               IMG_WIDTH  = conv_pkg::IMG_WIDTH_DEFAULT,
	parameter int               IMG_HEIGHT = conv_pkg::IMG_HEIGHT_DEFAULT,
	parameter conv_pkg::kernel_t KERNEL    = conv_pkg::SOBEL_X
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  start,
	input  logic [conv_pkg::PIXEL_W-1:0]          pixel_in,
	input  logic                                  pixel_valid,
	output logic signed [conv_pkg::RESULT_W-1:0]  result_out,
	output logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2))-1:0] result_index,
	output logic                                  result_valid,
	output logic                                  done
);

	localparam int K = conv_pkg::KERNEL_SIZE;
	localparam int IDX_W = $clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2));
	localparam int X_W = $clog2(IMG_WIDTH);
	localparam int Y_W = $clog2(IMG_HEIGHT);
	localparam int MW = conv_pkg::MAC_W;
	// window load, multiply and four adder stages.
	localparam int LAT = 6;
	localparam logic [X_W-1:0] X_LAST = X_W'(IMG_WIDTH-1);
	localparam logic [Y_W-1:0] Y_LAST = Y_W'(IMG_HEIGHT-1);

	typedef enum logic [1:0] {IDLE, PROCESSING, DRAIN, DONE} state_t;

	state_t state, next_state;

	logic [conv_pkg::PIXEL_W-1:0] line_buf1 [0:IMG_WIDTH-1];
	logic [conv_pkg::PIXEL_W-1:0] line_buf2 [0:IMG_WIDTH-1];
	logic [conv_pkg::PIXEL_W-1:0] window [0:K-1][0:K-1];

	logic signed [MW-1:0] mac_out [0:K-1][0:K-1];
	logic signed [MW:0]   sum_s1 [0:4];
	logic signed [MW+1:0] sum_s2 [0:2];
	logic signed [MW+2:0] sum_s3 [0:1];
	logic signed [conv_pkg::RESULT_W-1:0] final_sum;

	logic [X_W-1:0]   cnt_x;
	logic [Y_W-1:0]   cnt_y;
	logic [2:0]       drain_cnt;
	logic [IDX_W-1:0] idx_cnt;
	logic             accept;
	logic             last_pixel;
	logic             valid_in;
	logic [LAT-1:0]   valid_pipe;
	logic [IDX_W-1:0] idx_pipe [0:LAT-1];

	assign accept = pixel_valid && (state == PROCESSING);
	assign last_pixel = accept && (cnt_x == X_LAST) && (cnt_y == Y_LAST);
	// a full window exists once the lower-right pixel is at x >= 2 and y >= 2.
	assign valid_in = accept && (cnt_x >= X_W'(2)) && (cnt_y >= Y_W'(2));

	for (genvar i = 0; i < K; i++) begin : g_row
		for (genvar j = 0; j < K; j++) begin : g_col
			compute_unit u_mac (
				.clk      (clk),
				.rst      (rst),
				.pixel_a  (window[i][j]),
				.weight_b (KERNEL[i][j]),
				.sum_out  (mac_out[i][j])
			);
		end
	end

	// column 2 of the window takes the newest pixel and the two rows above it.
	always_ff @(posedge clk) begin
		if (accept) begin
			line_buf2[cnt_x] <= line_buf1[cnt_x];
			line_buf1[cnt_x] <= pixel_in;
			for (int r = 0; r < K; r++) begin
				window[r][0] <= window[r][1];
				window[r][1] <= window[r][2];
			end
			window[0][2] <= line_buf2[cnt_x];
			window[1][2] <= line_buf1[cnt_x];
			window[2][2] <= pixel_in;
		end
	end

	always_ff @(posedge clk) begin
		sum_s1[0] <= mac_out[0][0] + mac_out[0][1];
		sum_s1[1] <= mac_out[0][2] + mac_out[1][0];
		sum_s1[2] <= mac_out[1][1] + mac_out[1][2];
		sum_s1[3] <= mac_out[2][0] + mac_out[2][1];
		sum_s1[4] <= mac_out[2][2];
		sum_s2[0] <= sum_s1[0] + sum_s1[1];
		sum_s2[1] <= sum_s1[2] + sum_s1[3];
		sum_s2[2] <= sum_s1[4];
		sum_s3[0] <= sum_s2[0] + sum_s2[1];
		sum_s3[1] <= sum_s2[2];
		final_sum <= sum_s3[0] + sum_s3[1];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:       if (start) next_state = PROCESSING;
			PROCESSING: if (last_pixel) next_state = DRAIN;
			DRAIN:      if (drain_cnt == 3'd4) next_state = DONE;
			DONE:       next_state = IDLE;
			default:    next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || state == IDLE) begin
			cnt_x <= '0;
			cnt_y <= '0;
			idx_cnt <= '0;
		end else if (accept) begin
			if (cnt_x == X_LAST) begin
				cnt_x <= '0;
				cnt_y <= cnt_y + 1'b1;
			end else begin
				cnt_x <= cnt_x + 1'b1;
			end
			if (valid_in) begin
				idx_cnt <= idx_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || state != DRAIN) begin
			drain_cnt <= '0;
		end else begin
			drain_cnt <= drain_cnt + 1'b1;
		end
	end

	// index rides beside the valid bit through the pipeline.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[LAT-2:0], valid_in};
		end
		idx_pipe[0] <= idx_cnt;
		for (int s = 1; s < LAT; s++) begin
			idx_pipe[s] <= idx_pipe[s-1];
		end
	end

	assign result_out = final_sum;
	assign result_valid = valid_pipe[LAT-1];
	assign result_index = idx_pipe[LAT-1];
	assign done = (state == DONE);

endmodule

`default_nettype wire

//--- source/compute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module compute_unit (
	input  logic                                clk,
	input  logic                                rst,
	input  logic        [conv_pkg::PIXEL_W-1:0]  pixel_a,
	input  logic signed [conv_pkg::WEIGHT_W-1:0] weight_b,
	output logic signed [conv_pkg::MAC_W-1:0]    sum_out
);

	logic signed [conv_pkg::PIXEL_W:0] pixel_s;

	// pixels are unsigned, so add a zero sign bit.
	assign pixel_s = $signed({1'b0, pixel_a});

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_out <= '0;
		end else begin
			sum_out <= pixel_s * weight_b;
		end
	end

endmodule

`default_nettype wire

//--- source/conv_pkg.sv
`default_nettype none

package conv_pkg;

	// default frame size.
	localparam int IMG_WIDTH_DEFAULT = 32;
	localparam int IMG_HEIGHT_DEFAULT = 32;

	localparam int KERNEL_SIZE = 3;

	localparam int PIXEL_W = 8;
	localparam int WEIGHT_W = 8;

	// one product of a 9-bit zero-extended pixel and an 8-bit weight.
	localparam int MAC_W = 18;

	// sum of nine products after the four-stage adder tree.
	localparam int RESULT_W = 22;

	typedef logic signed [WEIGHT_W-1:0] weight_t;

	// row 0 is the top row, column 0 is the leftmost column.
	typedef weight_t [0:KERNEL_SIZE-1][0:KERNEL_SIZE-1] kernel_t;

	localparam kernel_t SOBEL_X = '{
		'{ 8'sd1, 8'sd0, -8'sd1},
		'{ 8'sd2, 8'sd0, -8'sd2},
		'{ 8'sd1, 8'sd0, -8'sd1}
	};

	localparam kernel_t SOBEL_Y = '{
		'{ 8'sd1,  8'sd2,  8'sd1},
		'{ 8'sd0,  8'sd0,  8'sd0},
		'{-8'sd1, -8'sd2, -8'sd1}
	};

endpackage

`default_nettype wire
